// ==== all.f ====
+incdir+include
hw/ifu_pkg.sv
hw/ifu_pace_lfsr.sv
hw/ifu_pc_gen.sv
hw/ifu_inst_check.sv
hw/ifu_fetch_ctrl.sv
hw/ifu_top.sv
test/ifu_assert.sv
test/ifu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module ifu_tb -o ifu_sim

output=$(./obj_dir/ifu_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// ==== test/ifu_tb.sv ====
//****************************************
// testbench for the instruction fetch unit
// plays the memory and the downstream stage
// and checks every fetch against a model
//****************************************
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_tb;
	import ifu_pkg::*;

	localparam int WAIT_LIMIT    = 200;
	localparam int FETCH_COUNT   = 300;
	localparam int PLAIN_FETCHES = 40;

	logic       clk;
	logic       rst;
	logic       ar_valid_o;
	logic       ar_ready_i;
	addr_t      ar_addr_o;
	logic       r_valid_i;
	logic       r_ready_o;
	inst_t      r_data_i;
	resp_t      r_resp_i;
	logic       last_finish_i;
	redirect_t  redirect_i;
	fetch_pkt_t fetch_o;
	logic       valid_o;

	logic [31:0] lfsr_state;
	addr_t       exp_pc;
	inst_t       mem_word;
	logic        beat_ok;
	int          fetches;

	ifu_top i_ifu_top (
		.clk           (clk),
		.rst           (rst),
		.ar_valid_o    (ar_valid_o),
		.ar_ready_i    (ar_ready_i),
		.ar_addr_o     (ar_addr_o),
		.r_valid_i     (r_valid_i),
		.r_ready_o     (r_ready_o),
		.r_data_i      (r_data_i),
		.r_resp_i      (r_resp_i),
		.last_finish_i (last_finish_i),
		.redirect_i    (redirect_i),
		.fetch_o       (fetch_o),
		.valid_o       (valid_o)
	);

	always #2 clk = ~clk;

	// one step of x^32 + x^22 + x^2 + x + 1 per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
		case (sel)
			4'd0: return `IFU_OP_LUI;
			4'd1: return `IFU_OP_AUIPC;
			4'd2: return `IFU_OP_JAL;
			4'd3: return `IFU_OP_JALR;
			4'd4: return `IFU_OP_BRANCH;
			4'd5: return `IFU_OP_LOAD;
			4'd6: return `IFU_OP_STORE;
			4'd7: return `IFU_OP_REG;
			4'd8: return `IFU_OP_SYSTEM;
			default: return `IFU_OP_IMM;
		endcase
	endfunction

	// exact system words, raw words, or a known opcode over random fields
	function automatic inst_t gen_word();
		inst_t      w;
		logic [3:0] kind;
		w = rand_bits(32);
		kind = 4'(rand_bits(4));
		case (kind)
			4'd0: w = `IFU_ECALL;
			4'd1: w = `IFU_EBREAK;
			4'd2: w = `IFU_MRET;
			default: begin
				if (kind[3]) begin
					w[6:0] = pick_opcode(4'(rand_bits(4)));
					// shift encodings need a clean or arithmetic upper field
					if (kind[0]) begin
						w[31:25] = (rand_bits(1) != 32'd0) ? `IFU_F7_SRA : `IFU_F7_ZERO;
					end
				end
			end
		endcase
		return w;
	endfunction

	function automatic logic model_illegal(input inst_t w);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ok;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		ok = 1'b0;
		if (op == `IFU_OP_LUI || op == `IFU_OP_AUIPC || op == `IFU_OP_JAL ||
			op == `IFU_OP_BRANCH || op == `IFU_OP_REG) begin
			ok = 1'b1;
		end
		if (op == `IFU_OP_JALR && f3 == 3'd0) begin
			ok = 1'b1;
		end
		if (op == `IFU_OP_LOAD && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
			ok = 1'b1;
		end
		if (op == `IFU_OP_STORE && f3 inside {3'd0, 3'd1, 3'd2}) begin
			ok = 1'b1;
		end
		if (op == `IFU_OP_IMM) begin
			if (f3 inside {3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7}) begin
				ok = 1'b1;
			end
			if ((f3 == 3'd1 || f3 == 3'd5) && f7 == 7'h00) begin
				ok = 1'b1;
			end
			if (f3 == 3'd5 && f7 == 7'h20) begin
				ok = 1'b1;
			end
		end
		if (op == `IFU_OP_SYSTEM && (f3 == 3'd1 || f3 == 3'd2)) begin
			ok = 1'b1;
		end
		if (w == `IFU_ECALL || w == `IFU_EBREAK || w == `IFU_MRET) begin
			ok = 1'b1;
		end
		return !ok;
	endfunction

	// lowest priority first so later sources overwrite
	function automatic addr_t model_next_pc(input addr_t pc, input redirect_t rd);
		addr_t n;
		n = pc + 32'd4;
		if (rd.br_request && rd.br_taken) begin
			n = rd.br_target;
		end
		if (rd.jmp_valid) begin
			n = rd.jmp_target;
		end
		if (rd.csr_valid) begin
			n = rd.csr_pc;
		end
		return n;
	endfunction

	function automatic redirect_t random_redirect();
		redirect_t rd;
		rd = '0;
		if (fetches >= PLAIN_FETCHES) begin
			rd.csr_valid  = (rand_bits(3) == 32'd0);
			rd.csr_pc     = rand_bits(30) << 2;
			rd.jmp_valid  = (rand_bits(2) == 32'd0);
			rd.jmp_target = rand_bits(30) << 2;
			rd.br_request = (rand_bits(1) != 32'd0);
			rd.br_taken   = (rand_bits(1) != 32'd0);
			rd.br_target  = rand_bits(30) << 2;
		end
		return rd;
	endfunction

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "address check");
		end
	endtask

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "instruction check");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "flag check");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
		$display("Test failed");
		$fatal(1, "wait limit reached");
	endtask

	// memory side of the address channel with random ready gaps
	task automatic request_addr();
		int   t;
		logic done;
		t = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			check_flag("valid_o", valid_o, 1'b0);
			check_flag("r_ready_o", r_ready_o, 1'b0);
			if (ar_valid_o && ar_ready_i) begin
				check_addr("ar_addr_o", ar_addr_o, exp_pc);
				ar_ready_i <= 1'b0;
				done = 1'b1;
			end else begin
				t++;
				if (t > WAIT_LIMIT) begin
					report_timeout("read address handshake");
				end
				ar_ready_i <= (rand_bits(2) != 32'd0);
			end
		end
	endtask

	// one data beat with about one in eight answered by an error
	task automatic return_data();
		inst_t word;
		resp_t resp;
		int    t;
		logic  done;
		word = gen_word();
		resp = `IFU_RESP_OKAY;
		if (rand_bits(3) == 32'd0) begin
			resp = resp_t'(32'd1 + rand_bits(1));
		end
		r_data_i  <= word;
		r_resp_i  <= resp;
		r_valid_i <= (rand_bits(1) != 32'd0);
		t = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			check_flag("valid_o", valid_o, 1'b0);
			check_flag("ar_valid_o", ar_valid_o, 1'b0);
			if (r_valid_i && r_ready_o) begin
				r_valid_i <= 1'b0;
				mem_word = word;
				beat_ok = (resp == `IFU_RESP_OKAY);
				done = 1'b1;
			end else begin
				t++;
				if (t > WAIT_LIMIT) begin
					report_timeout("read data handshake");
				end
				// once raised, valid holds until the beat is taken
				if (!r_valid_i) begin
					r_valid_i <= (rand_bits(1) != 32'd0);
				end
			end
		end
	endtask

	task automatic take_packet();
		int   t;
		logic done;
		t = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (valid_o) begin
				check_addr("fetch_o.pc", fetch_o.pc, exp_pc);
				check_inst("fetch_o.inst", fetch_o.inst, mem_word);
				check_flag("fetch_o.illegal", fetch_o.illegal, model_illegal(mem_word));
				done = 1'b1;
			end else begin
				t++;
				if (t > WAIT_LIMIT) begin
					report_timeout("valid_o pulse");
				end
			end
		end
	endtask

	// downstream holds the unit for a random and sometimes long stretch
	task automatic finish_downstream();
		int        hold;
		redirect_t rd;
		hold = int'(rand_bits(4));
		if (rand_bits(4) == 32'd0) begin
			hold = hold + 60;
		end
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			check_flag("ar_valid_o", ar_valid_o, 1'b0);
			check_flag("r_ready_o", r_ready_o, 1'b0);
			check_flag("valid_o", valid_o, 1'b0);
		end
		rd = random_redirect();
		redirect_i    <= rd;
		last_finish_i <= 1'b1;
		@(posedge clk);
		check_flag("ar_valid_o", ar_valid_o, 1'b0);
		last_finish_i <= 1'b0;
		exp_pc = model_next_pc(exp_pc, rd);
	endtask

	initial begin
		clk           = 1'b0;
		rst           = 1'b1;
		ar_ready_i    = 1'b0;
		r_valid_i     = 1'b0;
		r_data_i      = '0;
		r_resp_i      = '0;
		last_finish_i = 1'b0;
		redirect_i    = '0;
		lfsr_state    = 32'h6c37;
		exp_pc        = `IFU_RESET_PC;
		mem_word      = '0;
		beat_ok       = 1'b0;
		fetches       = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// an error beat means the same address comes round again
		while (fetches < FETCH_COUNT) begin
			request_addr();
			return_data();
			if (beat_ok) begin
				take_packet();
				finish_downstream();
				fetches++;
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/ifu_assert.sv ====
//****************************************
// protocol assertions for the fetch unit,
// bound into the top level
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_assert (
	input wire logic           clk,
	input wire logic           rst,
	input wire logic           ar_valid_i,
	input wire logic           ar_ready_i,
	input wire ifu_pkg::addr_t ar_addr_i,
	input wire logic           r_ready_i,
	input wire logic           valid_i
);

	// request and address hold until the memory takes them
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		(ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_addr_i)))
		else $error("read address request dropped or changed before ready");

	// packet strobe is a single cycle
	a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		valid_i |=> !valid_i)
		else $error("valid_o high on two cycles in a row");

	a_reset_quiet: assert property (@(posedge clk)
		(rst && $past(rst)) |-> (!ar_valid_i && !r_ready_i && !valid_i))
		else $error("control output high during reset");

endmodule

bind ifu_top ifu_assert i_ifu_assert (
	.clk        (clk),
	.rst        (rst),
	.ar_valid_i (ar_valid_o),
	.ar_ready_i (ar_ready_i),
	.ar_addr_i  (ar_addr_o),
	.r_ready_i  (r_ready_o),
	.valid_i    (valid_o)
);

`default_nettype wire

// ==== hw/ifu_top.sv ====
//****************************************
// instruction fetch front, top level
// read channel toward memory, packet and
// finish handshake toward the next stage
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
	input  wire logic                clk,
	input  wire logic                rst,
	output logic                     ar_valid_o,
	input  wire logic                ar_ready_i,
	output ifu_pkg::addr_t           ar_addr_o,
	input  wire logic                r_valid_i,
	output logic                     r_ready_o,
	input  wire ifu_pkg::inst_t      r_data_i,
	input  wire ifu_pkg::resp_t      r_resp_i,
	input  wire logic                last_finish_i,
	input  wire ifu_pkg::redirect_t  redirect_i,
	output ifu_pkg::fetch_pkt_t      fetch_o,
	output logic                     valid_o
);
	import ifu_pkg::*;

	addr_t  pc;
	delay_t delay;
	inst_t  inst;
	logic   reload;
	logic   pc_load;
	logic   illegal;

	ifu_fetch_ctrl i_ifu_fetch_ctrl (
		.clk           (clk),
		.rst           (rst),
		.pc_i          (pc),
		.delay_i       (delay),
		.illegal_i     (illegal),
		.last_finish_i (last_finish_i),
		.ar_ready_i    (ar_ready_i),
		.r_valid_i     (r_valid_i),
		.r_data_i      (r_data_i),
		.r_resp_i      (r_resp_i),
		.ar_valid_o    (ar_valid_o),
		.r_ready_o     (r_ready_o),
		.ar_addr_o     (ar_addr_o),
		.reload_o      (reload),
		.pc_load_o     (pc_load),
		.inst_o        (inst),
		.fetch_o       (fetch_o),
		.valid_o       (valid_o)
	);

	ifu_pc_gen i_ifu_pc_gen (
		.clk        (clk),
		.rst        (rst),
		.load_i     (pc_load),
		.redirect_i (redirect_i),
		.pc_o       (pc)
	);

	// legality of the captured word
	ifu_inst_check i_ifu_inst_check (
		.inst_i    (inst),
		.illegal_o (illegal)
	);

	ifu_pace_lfsr i_ifu_pace_lfsr (
		.clk      (clk),
		.rst      (rst),
		.reload_i (reload),
		.delay_o  (delay)
	);

endmodule

`default_nettype wire

// ==== hw/ifu_fetch_ctrl.sv ====
//****************************************
// fetch FSM, one read in flight at a time
// paces the read strobes, captures the word
// and hands the packet downstream
//****************************************
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_fetch_ctrl (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire ifu_pkg::addr_t      pc_i,
	input  wire ifu_pkg::delay_t     delay_i,
	input  wire logic                illegal_i,
	input  wire logic                last_finish_i,
	input  wire logic                ar_ready_i,
	input  wire logic                r_valid_i,
	input  wire ifu_pkg::inst_t      r_data_i,
	input  wire ifu_pkg::resp_t      r_resp_i,
	output logic                     ar_valid_o,
	output logic                     r_ready_o,
	output ifu_pkg::addr_t           ar_addr_o,
	output logic                     reload_o,
	output logic                     pc_load_o,
	output ifu_pkg::inst_t           inst_o,
	output ifu_pkg::fetch_pkt_t      fetch_o,
	output logic                     valid_o
);
	import ifu_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	delay_t       cnt_q;
	logic         ar_valid_q;
	logic         r_ready_q;
	logic         ar_hs;
	logic         r_hs;
	logic         r_ok;
	addr_t        ar_addr_q;
	addr_t        pc_cap_q;
	inst_t        inst_q;

	assign ar_hs = ar_valid_q & ar_ready_i;
	assign r_hs  = r_ready_q & r_valid_i;
	assign r_ok  = (r_resp_i == `IFU_RESP_OKAY);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_ADDR: begin
				if (ar_hs) begin
					state_d = ST_LOAD;
				end
			end
			ST_LOAD: begin
				// an error beat is dropped and the same pc is fetched again
				if (r_hs) begin
					state_d = r_ok ? ST_HAND : ST_ADDR;
				end
			end
			ST_HAND: begin
				state_d = ST_WAIT;
			end
			ST_WAIT: begin
				if (last_finish_i) begin
					state_d = ST_ADDR;
				end
			end
			default: begin
				state_d = ST_ADDR;
			end
		endcase
	end

	// new delay on entry to either read phase
	assign reload_o  = (state_d != state_q) && ((state_d == ST_ADDR) || (state_d == ST_LOAD));
	assign pc_load_o = (state_q == ST_WAIT) && last_finish_i;

	// counter restarts with each phase, strobe comes up once it meets the delay
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q    <= ST_ADDR;
			cnt_q      <= '0;
			ar_valid_q <= 1'b0;
			r_ready_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_d != state_q) begin
				cnt_q <= '0;
			end else if (cnt_q != delay_i) begin
				cnt_q <= cnt_q + delay_t'(1);
			end
			if (ar_hs) begin
				ar_valid_q <= 1'b0;
			end else if ((state_q == ST_ADDR) && (cnt_q == delay_i)) begin
				ar_valid_q <= 1'b1;
			end
			if (r_hs) begin
				r_ready_q <= 1'b0;
			end else if ((state_q == ST_LOAD) && (cnt_q == delay_i)) begin
				r_ready_q <= 1'b1;
			end
		end
	end

	// address follows pc until the request is raised, then holds
	always_ff @(posedge clk) begin
		if ((state_q == ST_ADDR) && !ar_valid_q) begin
			ar_addr_q <= pc_i;
		end
		if ((state_q == ST_LOAD) && r_hs && r_ok) begin
			pc_cap_q <= ar_addr_q;
			inst_q   <= r_data_i;
		end
	end

	assign ar_valid_o = ar_valid_q;
	assign r_ready_o  = r_ready_q;
	assign ar_addr_o  = ar_addr_q;
	assign inst_o     = inst_q;
	assign valid_o    = (state_q == ST_HAND);

	always_comb begin
		fetch_o.pc      = pc_cap_q;
		fetch_o.inst    = inst_q;
		fetch_o.illegal = illegal_i;
	end

endmodule

`default_nettype wire

// ==== hw/ifu_inst_check.sv ====
//****************************************
// legality check of a fetched word
// against the RV32I and CSR subset
//****************************************
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_inst_check (
	input  wire ifu_pkg::inst_t inst_i,
	output logic                illegal_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			`IFU_OP_LUI,
			`IFU_OP_AUIPC,
			`IFU_OP_JAL: begin
				legal = 1'b1;
			end
			`IFU_OP_JALR: begin
				legal = (funct3 == `IFU_F3_JALR);
			end
			`IFU_OP_BRANCH,
			`IFU_OP_REG: begin
				legal = 1'b1;
			end
			`IFU_OP_LOAD: begin
				legal = (funct3 == `IFU_F3_LB) || (funct3 == `IFU_F3_LH) ||
					(funct3 == `IFU_F3_LW) || (funct3 == `IFU_F3_LBU) ||
					(funct3 == `IFU_F3_LHU);
			end
			`IFU_OP_STORE: begin
				legal = (funct3 == `IFU_F3_SB) || (funct3 == `IFU_F3_SH) ||
					(funct3 == `IFU_F3_SW);
			end
			`IFU_OP_IMM: begin
				case (funct3)
					`IFU_F3_ADDI,
					`IFU_F3_SLTI,
					`IFU_F3_SLTIU,
					`IFU_F3_XORI,
					`IFU_F3_ORI,
					`IFU_F3_ANDI: begin
						legal = 1'b1;
					end
					// shifts only with a clean upper field
					`IFU_F3_SLLI: begin
						legal = (funct7 == `IFU_F7_ZERO);
					end
					`IFU_F3_SRI: begin
						legal = (funct7 == `IFU_F7_ZERO) || (funct7 == `IFU_F7_SRA);
					end
					default: begin
						legal = 1'b0;
					end
				endcase
			end
			`IFU_OP_SYSTEM: begin
				// csrrw and csrrs, or one of the exact system words
				legal = (funct3 == `IFU_F3_CSRRW) || (funct3 == `IFU_F3_CSRRS) ||
					(inst_i == `IFU_ECALL) || (inst_i == `IFU_EBREAK) ||
					(inst_i == `IFU_MRET);
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = ~legal;

endmodule

`default_nettype wire

// ==== hw/ifu_pc_gen.sv ====
//****************************************
// program counter of the fetch unit
// picks the next pc when the controller
// loads it after an instruction finishes
//****************************************
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_pc_gen (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               load_i,
	input  wire ifu_pkg::redirect_t redirect_i,
	output ifu_pkg::addr_t          pc_o
);
	import ifu_pkg::*;

	addr_t pc_q;
	addr_t pc_plus4;
	addr_t pc_next;

	assign pc_plus4 = pc_q + addr_t'(4);

	// csr beats jump, jump beats a taken branch
	always_comb begin
		if (redirect_i.csr_valid) begin
			pc_next = redirect_i.csr_pc;
		end else if (redirect_i.jmp_valid) begin
			pc_next = redirect_i.jmp_target;
		end else if (redirect_i.br_request && redirect_i.br_taken) begin
			pc_next = redirect_i.br_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `IFU_RESET_PC;
		end else if (load_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== hw/ifu_pace_lfsr.sv ====
//****************************************
// pacing source for the read strobes
// latches a new delay on each reload
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_pace_lfsr (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            reload_i,
	output ifu_pkg::delay_t      delay_o
);
	import ifu_pkg::*;

	localparam delay_t SEED = 4'b1001;

	delay_t lfsr_q;
	logic   feedback;

	// taps for x^4 + x^3 + 1, never reaches zero
	assign feedback = lfsr_q[3] ^ lfsr_q[2];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_q  <= SEED;
			delay_o <= '0;
		end else begin
			lfsr_q <= {lfsr_q[2:0], feedback};
			// held for the whole phase
			if (reload_i) begin
				delay_o <= lfsr_q;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/ifu_pkg.sv ====
//****************************************
// types shared by the fetch unit modules
// and by the testbench
//****************************************
`default_nettype none

`include "ifu_defs.svh"

package ifu_pkg;

	// plain vectors with a meaning
	typedef logic [`IFU_ADDR_W-1:0]  addr_t;
	typedef logic [`IFU_DATA_W-1:0]  inst_t;
	typedef logic [`IFU_RESP_W-1:0]  resp_t;
	typedef logic [`IFU_DELAY_W-1:0] delay_t;

	// redirect sources from the later stages
	typedef struct packed {
		logic  csr_valid;
		addr_t csr_pc;
		logic  jmp_valid;
		addr_t jmp_target;
		logic  br_request;
		logic  br_taken;
		addr_t br_target;
	} redirect_t;

	// packet handed downstream
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  illegal;
	} fetch_pkt_t;

	// fetch FSM states
	typedef enum logic [1:0] {
		ST_ADDR,
		ST_LOAD,
		ST_HAND,
		ST_WAIT
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== include/ifu_defs.svh ====
//****************************************
// constants for the instruction fetch unit
// widths, reset pc and RV32 decode codes
// include wherever a constant is needed
//****************************************
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// widths and reset pc
`define IFU_RESET_PC    32'h8000_0000
`define IFU_ADDR_W      32
`define IFU_DATA_W      32
`define IFU_RESP_W      2
`define IFU_DELAY_W     4
`define IFU_RESP_OKAY   2'b00

// major opcodes
`define IFU_OP_LUI      7'b0110111
`define IFU_OP_AUIPC    7'b0010111
`define IFU_OP_JAL      7'b1101111
`define IFU_OP_JALR     7'b1100111
`define IFU_OP_BRANCH   7'b1100011
`define IFU_OP_LOAD     7'b0000011
`define IFU_OP_STORE    7'b0100011
`define IFU_OP_IMM      7'b0010011
`define IFU_OP_REG      7'b0110011
`define IFU_OP_SYSTEM   7'b1110011

// funct3 codes
`define IFU_F3_JALR     3'b000
`define IFU_F3_LB       3'b000
`define IFU_F3_LH       3'b001
`define IFU_F3_LW       3'b010
`define IFU_F3_LBU      3'b100
`define IFU_F3_LHU      3'b101
`define IFU_F3_SB       3'b000
`define IFU_F3_SH       3'b001
`define IFU_F3_SW       3'b010
`define IFU_F3_ADDI     3'b000
`define IFU_F3_SLLI     3'b001
`define IFU_F3_SLTI     3'b010
`define IFU_F3_SLTIU    3'b011
`define IFU_F3_XORI     3'b100
`define IFU_F3_SRI      3'b101
`define IFU_F3_ORI      3'b110
`define IFU_F3_ANDI     3'b111
`define IFU_F3_CSRRW    3'b001
`define IFU_F3_CSRRS    3'b010

// funct7 codes for the immediate shifts
`define IFU_F7_ZERO     7'b0000000
`define IFU_F7_SRA      7'b0100000

// system instructions, whole words
`define IFU_ECALL       32'h0000_0073
`define IFU_EBREAK      32'h0010_0073
`define IFU_MRET        32'h3020_0073

`endif
